// ==== rtl/csr_map_pkg.sv ====
// ---------------------------------------
// Machine CSR address map, field bit
// positions and fixed register values
// ---------------------------------------
`default_nettype none

package csr_map_pkg;

  // Addresses of the implemented machine CSRs
  typedef enum logic [11:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MISA     = 12'h301,
    CSR_MIE      = 12'h304,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342,
    CSR_MTVAL    = 12'h343,
    CSR_MIP      = 12'h344
  } csr_addr_e;

  // mstatus fields, MPP is two bits wide
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP  = 11;

  // Legal MPP encodings, one bit per value (user 2'b00, machine 2'b11)
  localparam logic [3:0] MSTATUS_MPP_LEGAL = 4'b1001;

  // Interrupt bits, shared by mip and mie
  localparam int IRQ_BIT_MSI = 3;
  localparam int IRQ_BIT_MTI = 7;
  localparam int IRQ_BIT_MEI = 11;

  // misa extension field: I (bit 8) and U (bit 20)
  localparam logic [25:0] MISA_EXT = 26'h0100100;

endpackage : csr_map_pkg

`default_nettype wire

// ==== rtl/trap_pkg.sv ====
// ---------------------------------------
// Privilege levels and trap cause codes
// ---------------------------------------
`default_nettype none

package trap_pkg;

  typedef enum logic [1:0] {
    PRIV_USER    = 2'b00,
    PRIV_MACHINE = 2'b11
  } priv_e;

  typedef enum logic [3:0] {
    IRQ_SOFTWARE = 4'd3,
    IRQ_TIMER    = 4'd7,
    IRQ_EXTERNAL = 4'd11
  } irq_code_e;

  typedef enum logic [3:0] {
    EXC_ILLEGAL = 4'd2,
    EXC_ECALL_U = 4'd8,
    EXC_ECALL_M = 4'd11
  } exc_code_e;

  // Compact cause, flag goes to bit XLEN-1 when stored
  typedef struct packed {
    logic       interrupt;
    logic [3:0] code;
  } trap_cause_t;

endpackage : trap_pkg

`default_nettype wire

// ==== rtl/csr_trap_if.sv ====
// ---------------------------------------
// Trap events and machine status shared
// by the control and datapath blocks
// ---------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface csr_trap_if #(
  parameter int XLEN = 32
);
  import trap_pkg::*;

  logic            trap;
  trap_cause_t     cause;
  logic [XLEN-1:0] cause_word;
  logic            wr_commit;
  priv_e           priv;
  logic            mstatus_mie;
  logic            mstatus_mpie;
  priv_e           mstatus_mpp;
  // [2] external, [1] timer, [0] software
  logic [2:0]      irq_pending;
  logic [2:0]      irq_enable;

  // Cause as it is stored in mcause
  assign cause_word = {cause.interrupt, (XLEN - 1)'(cause.code)};

  modport control (
    output trap, cause, wr_commit, priv, mstatus_mie, mstatus_mpie, mstatus_mpp,
    input  irq_pending, irq_enable
  );

  modport regs (
    input  cause, wr_commit, mstatus_mie, mstatus_mpie, mstatus_mpp,
    output irq_pending, irq_enable
  );

  modport state (
    input trap, cause, cause_word, wr_commit, priv
  );

endinterface : csr_trap_if

`default_nettype wire

// ==== rtl/trap_control.sv ====
// ---------------------------------------
// Trap priority, privilege and mstatus
// state, mret handling and write gating
// ---------------------------------------
`timescale 1ns/10ps
`default_nettype none

module trap_control #(
  parameter int XLEN = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  illegal_instruction,
  input  logic                  ecall,
  input  logic                  mret,
  input  logic                  wr_en,
  input  csr_map_pkg::csr_addr_e addr,
  input  logic [XLEN-1:0]       wr_data,
  csr_trap_if.control           bus,
  output trap_pkg::priv_e       privilege_mode
);
  import csr_map_pkg::*;
  import trap_pkg::*;

  priv_e      priv;
  logic       mie;
  logic       mpie;
  priv_e      mpp;
  logic       irq_global;
  logic [2:0] irq_active;
  logic       wr_commit;
  logic       mstatus_wr;
  logic [1:0] wr_mpp;

  // User mode always takes machine interrupts
  assign irq_global = (priv == PRIV_USER) || mie;
  assign irq_active = bus.irq_pending & bus.irq_enable & {3{irq_global}};

  // Interrupts first, then illegal instruction, then ecall
  always_comb begin
    bus.trap  = 1'b1;
    bus.cause = '0;
    if (irq_active[2]) begin
      bus.cause.interrupt = 1'b1;
      bus.cause.code      = IRQ_EXTERNAL;
    end else if (irq_active[1]) begin
      bus.cause.interrupt = 1'b1;
      bus.cause.code      = IRQ_TIMER;
    end else if (irq_active[0]) begin
      bus.cause.interrupt = 1'b1;
      bus.cause.code      = IRQ_SOFTWARE;
    end else if (illegal_instruction) begin
      bus.cause.code = EXC_ILLEGAL;
    end else if (ecall) begin
      bus.cause.code = (priv == PRIV_USER) ? EXC_ECALL_U : EXC_ECALL_M;
    end else begin
      bus.trap = 1'b0;
    end
  end

  // A trap cancels any CSR write in the same cycle
  assign wr_commit     = wr_en && !bus.trap;
  assign bus.wr_commit = wr_commit;

  assign mstatus_wr = wr_commit && (addr == CSR_MSTATUS);
  assign wr_mpp     = wr_data[MSTATUS_MPP +: 2];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      priv <= PRIV_MACHINE;
      mie  <= 1'b0;
      mpie <= 1'b0;
      mpp  <= PRIV_USER;
    end else if (bus.trap) begin
      mpie <= mie;
      mie  <= 1'b0;
      mpp  <= priv;
      priv <= PRIV_MACHINE;
    end else if (mret) begin
      priv <= mpp;
      mie  <= mpie;
      mpie <= 1'b1;
      mpp  <= PRIV_USER;
    end else if (mstatus_wr) begin
      mie  <= wr_data[MSTATUS_MIE];
      mpie <= wr_data[MSTATUS_MPIE];
      // Unsupported MPP values keep the old mode
      if (MSTATUS_MPP_LEGAL[wr_mpp]) begin
        mpp <= priv_e'(wr_mpp);
      end
    end
  end

  assign bus.priv         = priv;
  assign bus.mstatus_mie  = mie;
  assign bus.mstatus_mpie = mpie;
  assign bus.mstatus_mpp  = mpp;
  assign privilege_mode   = priv;

  priv_legal_a : assert property (
    @(posedge clock) disable iff (reset) priv inside {PRIV_USER, PRIV_MACHINE}
  );

  // Issue stage must never combine these two
  mret_write_a : assert property (
    @(posedge clock) disable iff (reset) !(mret && wr_en)
  );

endmodule : trap_control

`default_nettype wire

// ==== rtl/csr_regs.sv ====
// ---------------------------------------
// mtvec, mie and mscratch, the CSR read
// mux and the trap target address
// ---------------------------------------
`timescale 1ns/10ps
`default_nettype none

module csr_regs #(
  parameter int XLEN       = 32,
  parameter int TIME_WIDTH = 64
) (
  input  logic                   clock,
  input  logic                   reset,
  input  csr_map_pkg::csr_addr_e addr,
  input  logic [XLEN-1:0]        wr_data,
  input  logic                   external_interrupt,
  input  logic                   software_interrupt,
  input  logic [TIME_WIDTH-1:0]  mtime,
  input  logic [TIME_WIDTH-1:0]  mtimecmp,
  input  logic [XLEN-1:0]        mepc,
  input  logic [XLEN-1:0]        mcause,
  input  logic [XLEN-1:0]        mtval,
  csr_trap_if.regs               bus,
  output logic [XLEN-1:0]        rd_data,
  output logic [XLEN-1:0]        trap_addr
);
  import csr_map_pkg::*;

  // MXL is 1 for RV32 and 2 for RV64
  localparam logic [XLEN-1:0] MISA_VALUE = {2'(XLEN / 32), {(XLEN - 28){1'b0}}, MISA_EXT};

  logic [XLEN-3:0] mtvec_base;
  logic            mtvec_vectored;
  logic [2:0]      irq_enable;
  logic [XLEN-1:0] mscratch;
  logic            timer_pending;
  logic [XLEN-1:0] mstatus_word;
  logic [XLEN-1:0] mie_word;
  logic [XLEN-1:0] mip_word;
  logic [XLEN-3:0] vector_offset;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mtvec_base     <= '0;
      mtvec_vectored <= 1'b0;
      irq_enable     <= '0;
      mscratch       <= '0;
    end else if (bus.wr_commit) begin
      case (addr)
        CSR_MTVEC: begin
          mtvec_base     <= wr_data[XLEN-1:2];
          mtvec_vectored <= wr_data[0];
        end
        CSR_MIE: begin
          irq_enable <= {wr_data[IRQ_BIT_MEI], wr_data[IRQ_BIT_MTI], wr_data[IRQ_BIT_MSI]};
        end
        CSR_MSCRATCH: mscratch <= wr_data;
        default: ;
      endcase
    end
  end

  // Timer fires once mtime reaches the compare value
  assign timer_pending   = mtime >= mtimecmp;
  assign bus.irq_pending = {external_interrupt, timer_pending, software_interrupt};
  assign bus.irq_enable  = irq_enable;

  always_comb begin
    mstatus_word                         = '0;
    mstatus_word[MSTATUS_MIE]            = bus.mstatus_mie;
    mstatus_word[MSTATUS_MPIE]           = bus.mstatus_mpie;
    mstatus_word[MSTATUS_MPP +: 2]       = bus.mstatus_mpp;

    mie_word                             = '0;
    mie_word[IRQ_BIT_MSI]                = irq_enable[0];
    mie_word[IRQ_BIT_MTI]                = irq_enable[1];
    mie_word[IRQ_BIT_MEI]                = irq_enable[2];

    mip_word                             = '0;
    mip_word[IRQ_BIT_MSI]                = software_interrupt;
    mip_word[IRQ_BIT_MTI]                = timer_pending;
    mip_word[IRQ_BIT_MEI]                = external_interrupt;
  end

  always_comb begin
    case (addr)
      CSR_MSTATUS:  rd_data = mstatus_word;
      CSR_MISA:     rd_data = MISA_VALUE;
      CSR_MIE:      rd_data = mie_word;
      CSR_MTVEC:    rd_data = {mtvec_base, 1'b0, mtvec_vectored};
      CSR_MSCRATCH: rd_data = mscratch;
      CSR_MEPC:     rd_data = mepc;
      CSR_MCAUSE:   rd_data = mcause;
      CSR_MTVAL:    rd_data = mtval;
      CSR_MIP:      rd_data = mip_word;
      default:      rd_data = '0;
    endcase
  end

  // Vectored mode offsets interrupts only, exceptions go to the base
  assign vector_offset = (mtvec_vectored && bus.cause.interrupt) ?
                         (XLEN - 2)'(bus.cause.code) : '0;
  assign trap_addr     = {mtvec_base + vector_offset, 2'b00};

  trap_addr_aligned_a : assert property (
    @(posedge clock) disable iff (reset) trap_addr[1:0] == 2'b00
  );

endmodule : csr_regs

`default_nettype wire

// ==== rtl/trap_state_regs.sv ====
// ---------------------------------------
// mepc, mcause and mtval, loaded on trap
// entry or by a committed CSR write
// ---------------------------------------
`timescale 1ns/10ps
`default_nettype none

module trap_state_regs #(
  parameter int XLEN = 32
) (
  input  logic                   clock,
  input  logic                   reset,
  input  csr_map_pkg::csr_addr_e addr,
  input  logic [XLEN-1:0]        wr_data,
  input  logic [XLEN-1:0]        pc,
  input  logic [31:0]            instruction,
  input  logic                   illegal_instruction,
  csr_trap_if.state              bus,
  output logic [XLEN-1:0]        mepc,
  output logic [XLEN-1:0]        mcause,
  output logic [XLEN-1:0]        mtval
);
  import csr_map_pkg::*;
  import trap_pkg::*;

  logic [XLEN-2:0] wr_code;
  logic            cause_legal;

  assign wr_code = wr_data[XLEN-2:0];

  // mcause only holds codes this unit can raise
  always_comb begin
    if (wr_data[XLEN-1]) begin
      cause_legal = wr_code inside {(XLEN - 1)'(IRQ_SOFTWARE), (XLEN - 1)'(IRQ_TIMER),
                                    (XLEN - 1)'(IRQ_EXTERNAL)};
    end else begin
      cause_legal = wr_code inside {(XLEN - 1)'(EXC_ILLEGAL), (XLEN - 1)'(EXC_ECALL_U),
                                    (XLEN - 1)'(EXC_ECALL_M)};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (bus.trap) begin
      mepc   <= pc;
      mcause <= bus.cause_word;
      // Faulting instruction word for illegal instruction only
      if (!bus.cause.interrupt && illegal_instruction) begin
        mtval <= XLEN'(instruction);
      end
    end else if (bus.wr_commit) begin
      case (addr)
        CSR_MEPC: mepc <= {wr_data[XLEN-1:2], 2'b00};
        CSR_MCAUSE: begin
          if (cause_legal) begin
            mcause <= wr_data;
          end
        end
        CSR_MTVAL: mtval <= wr_data;
        default: ;
      endcase
    end
  end

  no_write_on_trap_a : assert property (
    @(posedge clock) disable iff (reset) !(bus.trap && bus.wr_commit)
  );

endmodule : trap_state_regs

`default_nettype wire

// ==== rtl/csr_unit.sv ====
// ---------------------------------------
// Machine-mode CSR unit top level, plain
// ports toward the core pipeline
// ---------------------------------------
`timescale 1ns/10ps
`default_nettype none

module csr_unit #(
  parameter int XLEN       = 32,
  parameter int TIME_WIDTH = 64
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  wr_en,
  input  logic [11:0]           addr,
  input  logic [XLEN-1:0]       wr_data,
  output logic [XLEN-1:0]       rd_data,
  input  logic                  external_interrupt,
  input  logic                  software_interrupt,
  input  logic [TIME_WIDTH-1:0] mtime,
  input  logic [TIME_WIDTH-1:0] mtimecmp,
  input  logic [XLEN-1:0]       pc,
  input  logic [31:0]           instruction,
  input  logic                  illegal_instruction,
  input  logic                  ecall,
  input  logic                  mret,
  output logic                  trap,
  output logic [XLEN-1:0]       trap_addr,
  output logic [XLEN-1:0]       mepc,
  output trap_pkg::priv_e       privilege_mode
);
  import csr_map_pkg::*;

  csr_addr_e       csr_addr;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] mtval;

  // Unknown addresses fall to the read mux default
  assign csr_addr = csr_addr_e'(addr);

  csr_trap_if #(.XLEN(XLEN)) trap_bus ();

  trap_control #(
    .XLEN(XLEN)
  ) i_trap_control (
    .clock               (clock),
    .reset               (reset),
    .illegal_instruction (illegal_instruction),
    .ecall               (ecall),
    .mret                (mret),
    .wr_en               (wr_en),
    .addr                (csr_addr),
    .wr_data             (wr_data),
    .bus                 (trap_bus.control),
    .privilege_mode      (privilege_mode)
  );

  csr_regs #(
    .XLEN       (XLEN),
    .TIME_WIDTH (TIME_WIDTH)
  ) i_csr_regs (
    .clock              (clock),
    .reset              (reset),
    .addr               (csr_addr),
    .wr_data            (wr_data),
    .external_interrupt (external_interrupt),
    .software_interrupt (software_interrupt),
    .mtime              (mtime),
    .mtimecmp           (mtimecmp),
    .mepc               (mepc),
    .mcause             (mcause),
    .mtval              (mtval),
    .bus                (trap_bus.regs),
    .rd_data            (rd_data),
    .trap_addr          (trap_addr)
  );

  trap_state_regs #(
    .XLEN(XLEN)
  ) i_trap_state_regs (
    .clock               (clock),
    .reset               (reset),
    .addr                (csr_addr),
    .wr_data             (wr_data),
    .pc                  (pc),
    .instruction         (instruction),
    .illegal_instruction (illegal_instruction),
    .bus                 (trap_bus.state),
    .mepc                (mepc),
    .mcause              (mcause),
    .mtval               (mtval)
  );

  assign trap = trap_bus.trap;

endmodule : csr_unit

`default_nettype wire

// ==== verif/csr_unit_tb.sv ====
// ----------------------------------------
// Testbench for the CSR unit: a table of CSR and
// trap cases, then random mscratch traffic
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module csr_unit_tb;
  import csr_map_pkg::*;
  import trap_pkg::*;

  localparam int          XLEN         = 32;
  localparam int          RESET_CYCLES = 5;
  localparam int          RANDOM_PAIRS = 40;
  localparam logic [31:0] INSN         = 32'hc000_1073;

  // Row control bits
  localparam logic [6:0] NONE = 7'h00;
  localparam logic [6:0] WR   = 7'h40;
  localparam logic [6:0] ILL  = 7'h20;
  localparam logic [6:0] ECL  = 7'h10;
  localparam logic [6:0] MRT  = 7'h08;
  localparam logic [6:0] EXT  = 7'h04;
  localparam logic [6:0] SWI  = 7'h02;
  localparam logic [6:0] TMR  = 7'h01;

  // Outputs a row checks
  localparam logic [4:0] CT = 5'h10;
  localparam logic [4:0] CA = 5'h08;
  localparam logic [4:0] CR = 5'h04;
  localparam logic [4:0] CE = 5'h02;
  localparam logic [4:0] CP = 5'h01;

  localparam priv_e MACH = PRIV_MACHINE;
  localparam priv_e USR  = PRIV_USER;

  typedef struct {
    logic [6:0]      ctl;
    csr_addr_e       addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] pc;
    logic [4:0]      chk;
    logic            trap;
    logic [XLEN-1:0] trap_addr;
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] mepc;
    priv_e           priv;
  } row_t;

  logic            clock;
  logic            reset;
  logic            wr_en;
  logic [11:0]     addr;
  logic [XLEN-1:0] wr_data;
  logic [XLEN-1:0] rd_data;
  logic            external_interrupt;
  logic            software_interrupt;
  logic [63:0]     mtime;
  logic [63:0]     mtimecmp;
  logic [XLEN-1:0] pc;
  logic [31:0]     instruction;
  logic            illegal_instruction;
  logic            ecall;
  logic            mret;
  logic            trap;
  logic [XLEN-1:0] trap_addr;
  logic [XLEN-1:0] mepc;
  priv_e           privilege_mode;

  row_t rows[$];
  int   cycles = 0;

  // All testbench signals carry the DUT port names
  csr_unit #(.XLEN(XLEN), .TIME_WIDTH(64)) i_dut (.*);

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles = cycles + 1;
    if (cycles > 2 * rows.size() + 2 * RANDOM_PAIRS + RESET_CYCLES) begin
      report_failure("Timeout: the test did not finish within its cycle limit");
    end
  end

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("[FAIL] time %0t %s expected %h got %h",
                               $time, name, expected, actual));
    end
  endtask

  task automatic check_priv(input string name, input priv_e expected, input priv_e actual);
    if (actual !== expected) begin
      report_failure($sformatf("[FAIL] time %0t %s expected %b got %b",
                               $time, name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("[FAIL] time %0t %s expected %b got %b",
                               $time, name, expected, actual));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_row(input logic [6:0] ctl, input csr_addr_e addr_sel,
                         input logic [XLEN-1:0] wdata, input logic [XLEN-1:0] pc_val,
                         input logic [4:0] chk, input logic trap_exp,
                         input logic [XLEN-1:0] taddr_exp, input logic [XLEN-1:0] rd_exp,
                         input logic [XLEN-1:0] mepc_exp, input priv_e priv_exp);
    row_t r;
    r = '{ctl, addr_sel, wdata, pc_val, chk, trap_exp, taddr_exp, rd_exp, mepc_exp, priv_exp};
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Reset values and misa
    add_row(NONE, CSR_MSTATUS, 0, 0, CT | CR | CP, 1'b0, 0, 0, 0, MACH);
    add_row(NONE, CSR_MTVEC, 0, 0, CR, 1'b0, 0, 0, 0, MACH);
    add_row(NONE, CSR_MSCRATCH, 0, 0, CR, 1'b0, 0, 0, 0, MACH);
    add_row(NONE, CSR_MISA, 0, 0, CR, 1'b0, 0, 'h4010_0100, 0, MACH);
    // Write masking
    add_row(WR, CSR_MTVEC, 'hffff_ffff, 0, CT, 1'b0, 0, 0, 0, MACH);
    add_row(NONE, CSR_MTVEC, 0, 0, CR, 1'b0, 0, 'hffff_fffd, 0, MACH);
    add_row(WR, CSR_MEPC, 'h1237, 0, CR, 1'b0, 0, 0, 0, MACH);
    add_row(NONE, CSR_MEPC, 0, 0, CR | CE, 1'b0, 0, 'h1234, 'h1234, MACH);
    add_row(WR, CSR_MSTATUS, 'h1800, 0, CR, 1'b0, 0, 0, 0, MACH);
    add_row(WR, CSR_MSTATUS, 'h1080, 0, CR, 1'b0, 0, 'h1800, 0, MACH);
    add_row(NONE, CSR_MSTATUS, 0, 0, CR, 1'b0, 0, 'h1880, 0, MACH);
    add_row(WR, CSR_MCAUSE, 'h5, 0, CR, 1'b0, 0, 0, 0, MACH);
    add_row(WR, CSR_MCAUSE, 'h8000_0007, 0, CR, 1'b0, 0, 0, 0, MACH);
    add_row(NONE, CSR_MCAUSE, 0, 0, CR, 1'b0, 0, 'h8000_0007, 0, MACH);
    add_row(WR, CSR_MTVEC, 'h100, 0, CT, 1'b0, 0, 0, 0, MACH);
    // Exceptions, the mscratch write is dropped by the trap
    add_row(WR | ECL, CSR_MSCRATCH, 'h5555, 'h2000, CT | CA | CR | CP, 1'b1, 'h100, 0, 0, MACH);
    add_row(NONE, CSR_MSCRATCH, 0, 0, CR | CE, 1'b0, 0, 0, 'h2000, MACH);
    add_row(NONE, CSR_MCAUSE, 0, 0, CR, 1'b0, 0, 'hb, 0, MACH);
    add_row(WR, CSR_MSTATUS, 'h0080, 0, CR, 1'b0, 0, 'h1800, 0, MACH);
    add_row(MRT, CSR_MSTATUS, 0, 0, CT | CR | CP, 1'b0, 0, 'h0080, 0, MACH);
    add_row(NONE, CSR_MSTATUS, 0, 0, CR | CP, 1'b0, 0, 'h0088, 0, USR);
    add_row(ECL, CSR_MSTATUS, 0, 'h3000, CT | CA | CP, 1'b1, 'h100, 0, 0, USR);
    add_row(NONE, CSR_MCAUSE, 0, 0, CR | CE | CP, 1'b0, 0, 'h8, 'h3000, MACH);
    add_row(ILL, CSR_MCAUSE, 0, 'h4000, CT | CA | CR, 1'b1, 'h100, 'h8, 0, MACH);
    add_row(NONE, CSR_MTVAL, 0, 0, CR | CE, 1'b0, 0, INSN, 'h4000, MACH);
    add_row(NONE, CSR_MCAUSE, 0, 0, CR, 1'b0, 0, 'h2, 0, MACH);
    // mret back into machine mode
    add_row(MRT, CSR_MSTATUS, 0, 0, CT | CR | CP, 1'b0, 0, 'h1800, 0, MACH);
    add_row(NONE, CSR_MSTATUS, 0, 0, CR | CP, 1'b0, 0, 'h0080, 0, MACH);
    // Interrupts
    add_row(WR, CSR_MIE, 'h888, 0, CT, 1'b0, 0, 0, 0, MACH);
    add_row(SWI, CSR_MIP, 0, 0, CT | CR, 1'b0, 0, 'h8, 0, MACH);
    add_row(WR | SWI, CSR_MSTATUS, 'h0008, 0, CT, 1'b0, 0, 0, 0, MACH);
    add_row(SWI, CSR_MIE, 0, 'h5000, CT | CA | CR, 1'b1, 'h100, 'h888, 0, MACH);
    add_row(NONE, CSR_MCAUSE, 0, 0, CR | CE, 1'b0, 0, 'h8000_0003, 'h5000, MACH);
    add_row(WR, CSR_MTVEC, 'h101, 0, CR, 1'b0, 0, 'h100, 0, MACH);
    add_row(WR, CSR_MSTATUS, 'h0008, 0, CR, 1'b0, 0, 'h1880, 0, MACH);
    // All three pending, external wins, vectored target
    add_row(EXT | SWI | TMR, CSR_MTVEC, 0, 'h6000, CT | CA | CR, 1'b1, 'h12c, 'h101, 0, MACH);
    add_row(NONE, CSR_MCAUSE, 0, 0, CR | CE, 1'b0, 0, 'h8000_000b, 'h6000, MACH);
    add_row(WR, CSR_MSTATUS, 'h0000, 0, CR, 1'b0, 0, 'h1880, 0, MACH);
    add_row(MRT, CSR_MSTATUS, 0, 0, CT | CR, 1'b0, 0, 'h0000, 0, MACH);
    // User mode takes the timer with MIE clear
    add_row(TMR, CSR_MSTATUS, 0, 'h7000, CT | CA | CR | CP, 1'b1, 'h11c, 'h0080, 0, USR);
    add_row(NONE, CSR_MCAUSE, 0, 0, CR | CE | CP, 1'b0, 0, 'h8000_0007, 'h7000, MACH);
    // Masked external in machine mode, ecall goes to the base
    add_row(ECL | EXT, CSR_MCAUSE, 0, 'h8000, CT | CA | CR, 1'b1, 'h100, 'h8000_0007, 0, MACH);
    add_row(NONE, CSR_MCAUSE, 0, 0, CR | CE, 1'b0, 0, 'hb, 'h8000, MACH);
  endtask

  task automatic apply_row(input row_t r);
    wr_en               = r.ctl[6];
    illegal_instruction = r.ctl[5];
    ecall               = r.ctl[4];
    mret                = r.ctl[3];
    external_interrupt  = r.ctl[2];
    software_interrupt  = r.ctl[1];
    // Timer pending exactly at the compare value
    mtime               = r.ctl[0] ? 64'd100 : 64'd0;
    addr                = r.addr;
    wr_data             = r.wdata;
    pc                  = r.pc;
  endtask

  task automatic check_row(input row_t r);
    if (r.chk[4]) check_bit("trap", r.trap, trap);
    if (r.chk[3]) check_data("trap_addr", r.trap_addr, trap_addr);
    if (r.chk[2]) check_data("rd_data", r.rd_data, rd_data);
    if (r.chk[1]) check_data("mepc", r.mepc, mepc);
    if (r.chk[0]) check_priv("privilege_mode", r.priv, privilege_mode);
  endtask

  initial begin
    logic [31:0] value;
    clock               = 1'b0;
    reset               = 1'b1;
    wr_en               = 1'b0;
    addr                = '0;
    wr_data             = '0;
    external_interrupt  = 1'b0;
    software_interrupt  = 1'b0;
    mtime               = 64'd0;
    mtimecmp            = 64'd100;
    pc                  = '0;
    instruction         = INSN;
    illegal_instruction = 1'b0;
    ecall               = 1'b0;
    mret                = 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clock);
    #2 reset = 1'b0;

    foreach (rows[i]) begin
      @(posedge clock);
      #2;
      apply_row(rows[i]);
      #16;
      check_row(rows[i]);
    end

    // Random mscratch write and readback pairs
    value = 32'h7c66e351;
    repeat (RANDOM_PAIRS) begin
      value = xorshift(value);
      @(posedge clock);
      #2;
      wr_en   = 1'b1;
      addr    = CSR_MSCRATCH;
      wr_data = value;
      @(posedge clock);
      #2;
      wr_en = 1'b0;
      #16;
      check_data("rd_data", value, rd_data);
    end

    $display("STATUS: PASS");
    $finish;
  end

endmodule : csr_unit_tb

`default_nettype wire

// ==== tb.f ====
rtl/csr_map_pkg.sv
rtl/trap_pkg.sv
rtl/csr_trap_if.sv
rtl/trap_control.sv
rtl/csr_regs.sv
rtl/trap_state_regs.sv
rtl/csr_unit.sv
verif/csr_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
out=$( { verilator --binary --timing --assert --top-module csr_unit_tb -f tb.f \
  && ./obj_dir/Vcsr_unit_tb; } 2>&1 )
echo "$out"
echo "$out" | grep -q "STATUS: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
